// ==== common/mem_pkg.sv ====
// types shared by the fetch unit, the load/store lane and the bus arbiter
// mem_op_e values are the MIPS primary opcodes, so the instruction field maps directly
`default_nettype none

package mem_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] byte_en_t;

	// loads and stores kept from the core without LWL and LWR
	typedef enum logic [5:0] {
		op_lb  = 6'b100000,
		op_lh  = 6'b100001,
		op_lw  = 6'b100011,
		op_lbu = 6'b100100,
		op_lhu = 6'b100101,
		op_sb  = 6'b101000,
		op_sh  = 6'b101001,
		op_sw  = 6'b101011
	} mem_op_e;

	// store value sits in the low bits of wdata
	typedef struct packed {
		mem_op_e op;
		word_t addr;
		word_t wdata;
	} data_req_t;

	// one Avalon transfer as seen on the pins
	typedef struct packed {
		word_t address;
		byte_en_t byteenable;
		word_t writedata;
		logic read;
		logic write;
	} bus_req_t;

	typedef struct packed {
		word_t pc;
		word_t instr;
	} fetch_word_t;

endpackage

`default_nettype wire

// ==== fetch/instr_fetch.sv ====
// sequential word fetch into a one-entry buffer
// low bits of redirect_pc are dropped; reset_vector must be word aligned
`default_nettype none

module instr_fetch #(
	parameter mem_pkg::word_t reset_vector = 32'hBFC00000
) (
	input  logic clk,
	input  logic reset,
	input  logic redirect_valid,
	input  mem_pkg::word_t redirect_pc,
	output logic instr_valid,
	input  logic instr_ready,
	output mem_pkg::fetch_word_t instr,
	output logic fetch_req_valid,
	input  logic fetch_req_ready,
	output mem_pkg::bus_req_t fetch_req,
	input  logic fetch_done,
	input  mem_pkg::word_t rdata
);
	import mem_pkg::*;

	word_t pc;
	logic outstanding;
	logic stale;
	logic buf_valid;
	fetch_word_t buf_q;
	logic fetch_fire;
	logic instr_fire;

	assign fetch_fire = fetch_req_valid & fetch_req_ready;
	assign instr_fire = instr_valid & instr_ready;

	// one read at a time, and only into an empty buffer
	assign fetch_req_valid = !buf_valid && !outstanding;

	always_comb begin
		fetch_req = '0;
		fetch_req.address = pc;
		fetch_req.byteenable = 4'b1111;
		fetch_req.read = 1'b1;
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			pc <= reset_vector;
			outstanding <= 1'b0;
			stale <= 1'b0;
			buf_valid <= 1'b0;
		end else begin
			if (fetch_fire) begin
				outstanding <= 1'b1;
			end else if (fetch_done) begin
				outstanding <= 1'b0;
			end
			// a read still on the bus after a redirect returns old data
			if (redirect_valid && (fetch_fire || (outstanding && !fetch_done))) begin
				stale <= 1'b1;
			end else if (fetch_done) begin
				stale <= 1'b0;
			end
			if (redirect_valid) begin
				buf_valid <= 1'b0;
				pc <= {redirect_pc[31:2], 2'b00};
			end else if (fetch_done && !stale) begin
				buf_valid <= 1'b1;
			end else if (instr_fire) begin
				buf_valid <= 1'b0;
				pc <= buf_q.pc + 32'd4;
			end
		end
	end

	// pc is steady while a non-stale fetch is out
	always_ff @(posedge clk) begin
		if (fetch_done) begin
			buf_q.pc <= pc;
			buf_q.instr <= rdata;
		end
	end

	assign instr_valid = buf_valid;
	assign instr = buf_q;

endmodule

`default_nettype wire

// ==== data/load_store_lane.sv ====
// one MIPS load or store at a time, mapped onto a single Avalon transfer
// misaligned halfword and word addresses ignore the low bits as in the core
`default_nettype none

module load_store_lane (
	input  logic clk,
	input  logic reset,
	input  logic data_req_valid,
	output logic data_req_ready,
	input  mem_pkg::data_req_t data_req,
	output logic data_resp_valid,
	input  logic data_resp_ready,
	output mem_pkg::word_t load_data,
	output logic lane_req_valid,
	input  logic lane_req_ready,
	output mem_pkg::bus_req_t lane_req,
	input  logic lane_done,
	input  mem_pkg::word_t rdata
);
	import mem_pkg::*;

	logic busy;
	logic req_pending;
	logic resp_valid;
	logic accept;
	logic is_store;
	mem_op_e op_q;
	logic [1:0] offset_q;
	bus_req_t req_d;
	bus_req_t req_q;
	word_t load_d;
	word_t load_q;
	logic [7:0] byte_sel;
	logic [15:0] half_sel;

	// busy from acceptance until the response is taken
	assign data_req_ready = !busy;
	assign accept = data_req_valid & data_req_ready;

	always_comb begin
		req_d = '0;
		req_d.address = {data_req.addr[31:2], 2'b00};
		case (data_req.op)
			op_lb, op_lbu, op_sb: begin
				req_d.byteenable = 4'b0001 << data_req.addr[1:0];
				req_d.writedata = {4{data_req.wdata[7:0]}};
			end
			op_lh, op_lhu, op_sh: begin
				req_d.byteenable = data_req.addr[1] ? 4'b1100 : 4'b0011;
				req_d.writedata = {2{data_req.wdata[15:0]}};
			end
			default: begin
				req_d.byteenable = 4'b1111;
				req_d.writedata = data_req.wdata;
			end
		endcase
		is_store = data_req.op inside {op_sb, op_sh, op_sw};
		req_d.write = is_store;
		req_d.read = !is_store;
	end

	// pick the addressed lane out of the read word and extend it
	always_comb begin
		byte_sel = rdata[8*offset_q +: 8];
		half_sel = offset_q[1] ? rdata[31:16] : rdata[15:0];
		case (op_q)
			op_lb: load_d = {{24{byte_sel[7]}}, byte_sel};
			op_lbu: load_d = {24'b0, byte_sel};
			op_lh: load_d = {{16{half_sel[15]}}, half_sel};
			op_lhu: load_d = {16'b0, half_sel};
			op_lw: load_d = rdata;
			// stores answer with zero
			default: load_d = '0;
		endcase
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			req_pending <= 1'b0;
			resp_valid <= 1'b0;
		end else begin
			if (accept) begin
				busy <= 1'b1;
				req_pending <= 1'b1;
			end else if (lane_req_valid && lane_req_ready) begin
				req_pending <= 1'b0;
			end
			if (lane_done) begin
				resp_valid <= 1'b1;
			end else if (data_resp_valid && data_resp_ready) begin
				resp_valid <= 1'b0;
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= req_d;
			op_q <= data_req.op;
			offset_q <= data_req.addr[1:0];
		end
		if (lane_done) begin
			load_q <= load_d;
		end
	end

	assign lane_req_valid = req_pending;
	assign lane_req = req_q;
	assign data_resp_valid = resp_valid;
	assign load_data = load_q;

endmodule

`default_nettype wire

// ==== logic/bus_arbiter.sv ====
// shares one Avalon master port between fetch and data requests
// one transfer on the bus at a time; a grant costs one idle cycle
`default_nettype none

module bus_arbiter (
	input  logic clk,
	input  logic reset,
	input  logic fetch_req_valid,
	output logic fetch_req_ready,
	input  mem_pkg::bus_req_t fetch_req,
	input  logic lane_req_valid,
	output logic lane_req_ready,
	input  mem_pkg::bus_req_t lane_req,
	output logic fetch_done,
	output logic lane_done,
	output mem_pkg::word_t rdata,
	output mem_pkg::word_t address,
	output logic read,
	output logic write,
	output mem_pkg::word_t writedata,
	output mem_pkg::byte_en_t byteenable,
	input  logic waitrequest,
	input  mem_pkg::word_t readdata
);
	import mem_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_fetch,
		st_data
	} arb_state_e;

	arb_state_e state;
	logic last_lane;
	logic grant_fetch;
	logic grant_lane;
	logic busy;
	bus_req_t bus_q;

	// on a tie the requester not granted last time wins
	assign grant_lane = (state == st_idle) && lane_req_valid && (!fetch_req_valid || !last_lane);
	assign grant_fetch = (state == st_idle) && fetch_req_valid && !grant_lane;

	assign fetch_req_ready = grant_fetch;
	assign lane_req_ready = grant_lane;
	assign busy = (state != st_idle);

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state <= st_idle;
			last_lane <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (grant_lane) begin
						state <= st_data;
						last_lane <= 1'b1;
					end else if (grant_fetch) begin
						state <= st_fetch;
						last_lane <= 1'b0;
					end
				end
				st_fetch, st_data: begin
					if (!waitrequest) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// request captured at grant, held on the pins through waitrequest
	always_ff @(posedge clk) begin
		if (grant_lane) begin
			bus_q <= lane_req;
		end else if (grant_fetch) begin
			bus_q <= fetch_req;
		end
	end

	assign address = bus_q.address;
	assign byteenable = bus_q.byteenable;
	assign writedata = bus_q.writedata;
	assign read = busy & bus_q.read;
	assign write = busy & bus_q.write;

	// readdata is valid in the completing cycle only
	assign fetch_done = (state == st_fetch) && !waitrequest;
	assign lane_done = (state == st_data) && !waitrequest;
	assign rdata = readdata;

endmodule

`default_nettype wire

// ==== logic/mips_mem_bus.sv ====
// memory side of the pipelined MIPS core on a single Avalon master
// fetch and data run side by side; both latencies vary with waitrequest
`default_nettype none

module mips_mem_bus #(
	parameter mem_pkg::word_t reset_vector = 32'hBFC00000
) (
	input  logic clk,
	input  logic reset,
	output mem_pkg::word_t address,
	output logic read,
	output logic write,
	output mem_pkg::word_t writedata,
	output mem_pkg::byte_en_t byteenable,
	input  logic waitrequest,
	input  mem_pkg::word_t readdata,
	input  logic redirect_valid,
	input  mem_pkg::word_t redirect_pc,
	output logic instr_valid,
	input  logic instr_ready,
	output mem_pkg::fetch_word_t instr,
	input  logic data_req_valid,
	output logic data_req_ready,
	input  mem_pkg::data_req_t data_req,
	output logic data_resp_valid,
	input  logic data_resp_ready,
	output mem_pkg::word_t load_data
);
	import mem_pkg::*;

	logic fetch_req_valid;
	logic fetch_req_ready;
	bus_req_t fetch_req;
	logic lane_req_valid;
	logic lane_req_ready;
	bus_req_t lane_req;
	logic fetch_done;
	logic lane_done;
	word_t rdata;

	instr_fetch #(
		.reset_vector(reset_vector)
	) u_fetch (
		.clk(clk),
		.reset(reset),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.instr_valid(instr_valid),
		.instr_ready(instr_ready),
		.instr(instr),
		.fetch_req_valid(fetch_req_valid),
		.fetch_req_ready(fetch_req_ready),
		.fetch_req(fetch_req),
		.fetch_done(fetch_done),
		.rdata(rdata)
	);

	load_store_lane u_lane (
		.clk(clk),
		.reset(reset),
		.data_req_valid(data_req_valid),
		.data_req_ready(data_req_ready),
		.data_req(data_req),
		.data_resp_valid(data_resp_valid),
		.data_resp_ready(data_resp_ready),
		.load_data(load_data),
		.lane_req_valid(lane_req_valid),
		.lane_req_ready(lane_req_ready),
		.lane_req(lane_req),
		.lane_done(lane_done),
		.rdata(rdata)
	);

	bus_arbiter u_arbiter (
		.clk(clk),
		.reset(reset),
		.fetch_req_valid(fetch_req_valid),
		.fetch_req_ready(fetch_req_ready),
		.fetch_req(fetch_req),
		.lane_req_valid(lane_req_valid),
		.lane_req_ready(lane_req_ready),
		.lane_req(lane_req),
		.fetch_done(fetch_done),
		.lane_done(lane_done),
		.rdata(rdata),
		.address(address),
		.read(read),
		.write(write),
		.writedata(writedata),
		.byteenable(byteenable),
		.waitrequest(waitrequest),
		.readdata(readdata)
	);

endmodule

`default_nettype wire

// ==== verif/mips_mem_bus_sva.sv ====
// Avalon master protocol checks on the arbiter pins
// checks are disabled while reset is high
`default_nettype none

module mips_mem_bus_sva (
	input logic clk,
	input logic reset,
	input mem_pkg::word_t address,
	input logic read,
	input logic write,
	input mem_pkg::word_t writedata,
	input mem_pkg::byte_en_t byteenable,
	input logic waitrequest
);
	int failures = 0;

	read_write_excl: assert property (@(posedge clk) disable iff (reset) !(read && write))
		else begin
			$error("read and write high together");
			failures++;
		end

	// slave stall freezes the whole request
	hold_on_wait: assert property (@(posedge clk) disable iff (reset)
		(read || write) && waitrequest |=> $stable(address) && $stable(byteenable)
			&& $stable(writedata) && $stable(read) && $stable(write))
		else begin
			$error("request changed while waitrequest was high");
			failures++;
		end

	enable_nonzero: assert property (@(posedge clk) disable iff (reset)
		(read || write) |-> byteenable != 4'b0000)
		else begin
			$error("transfer with no byte lane enabled");
			failures++;
		end

endmodule

bind bus_arbiter mips_mem_bus_sva bus_checks (
	.clk(clk),
	.reset(reset),
	.address(address),
	.read(read),
	.write(write),
	.writedata(writedata),
	.byteenable(byteenable),
	.waitrequest(waitrequest)
);

`default_nettype wire

// ==== verif/tb_mips_mem_bus.sv ====
// trace-driven testbench for mips_mem_bus with an Avalon memory model
// run from the project root; code lives at 0xBxxxxxxx and data must stay outside it
`default_nettype none

module tb_mips_mem_bus;
	import mem_pkg::*;

	localparam word_t reset_vector = 32'hBFC00000;
	localparam int wait_limit = 200;

	logic clk = 1'b0;
	logic reset = 1'b1;
	word_t address;
	word_t writedata;
	byte_en_t byteenable;
	logic read;
	logic write;
	logic waitrequest = 1'b1;
	word_t readdata = '0;
	logic redirect_valid = 1'b0;
	word_t redirect_pc = '0;
	logic instr_valid;
	logic instr_ready = 1'b0;
	fetch_word_t instr;
	logic data_req_valid = 1'b0;
	logic data_req_ready;
	data_req_t data_req = '0;
	logic data_resp_valid;
	logic data_resp_ready = 1'b0;
	word_t load_data;

	logic [31:0] mem [logic [29:0]];
	logic [31:0] rand_state = 32'h65b1;
	word_t store_word;
	word_t expected_pc = reset_vector;
	int instr_count = 0;
	int req_count = 0;
	int resp_count = 0;
	int value_errors = 0;
	int other_errors = 0;
	int monitor_errors = 0;

	mips_mem_bus #(
		.reset_vector(reset_vector)
	) dut (.*);

	always #10 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// unwritten words read back a pattern built from the whole address
	function automatic word_t mem_read(input word_t a);
		if (mem.exists(a[31:2]))
			return mem[a[31:2]];
		return {a[15:0], a[31:16]} ^ 32'h5a5a_a5a5;
	endfunction

	// Avalon slave and random back-pressure just after each edge
	always @(posedge clk) begin
		#1;
		rand_state = lcg_next(rand_state);
		waitrequest = rand_state[31] & rand_state[29];
		instr_ready = rand_state[27:26] != 2'b00;
		data_resp_ready = rand_state[24:23] != 2'b00;
		readdata = read ? mem_read(address) : '0;
		if (write && !waitrequest) begin
			store_word = mem_read(address);
			for (int i = 0; i < 4; i++) begin
				if (byteenable[i])
					store_word[8*i +: 8] = writedata[8*i +: 8];
			end
			mem[address[31:2]] = store_word;
		end
	end

	// instruction stream follows the pc sequence and matches memory
	always @(negedge clk) begin
		if (!reset && instr_valid && instr_ready) begin
			assert (instr.pc == expected_pc) else begin
				$display("** Error at %0t: instr.pc = %h, expected %h",
					$time, instr.pc, expected_pc);
				monitor_errors++;
			end
			assert (instr.instr == mem_read(expected_pc)) else begin
				$display("** Error at %0t: instr.instr = %h, expected %h",
					$time, instr.instr, mem_read(expected_pc));
				monitor_errors++;
			end
			expected_pc = expected_pc + 32'd4;
			instr_count++;
		end
		if (redirect_valid) begin
			expected_pc = redirect_pc;
			instr_count = 0;
		end
		if (data_resp_valid && data_resp_ready)
			resp_count++;
		assert (resp_count <= req_count) else begin
			$display("** Error at %0t: data response arrived with no request outstanding", $time);
			monitor_errors++;
		end
	end

	task automatic wait_for_instrs(input int min_count, output logic ok);
		int n;
		n = 0;
		@(posedge clk);
		while (instr_count < min_count && n < wait_limit) begin
			@(posedge clk);
			n++;
		end
		ok = instr_count >= min_count;
		if (!ok) begin
			$display("** Error at %0t: instructions stopped arriving", $time);
			other_errors++;
		end
	endtask

	// redirect while a fetch read is stalled on the bus
	task automatic run_redirect(input word_t target, input int min_count, output logic ok);
		int n;
		wait_for_instrs(min_count, ok);
		if (!ok)
			return;
		n = 0;
		@(negedge clk);
		while (!(read && waitrequest && address[31:28] == 4'hb) && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (!(read && waitrequest && address[31:28] == 4'hb)) begin
			$display("** Error at %0t: no stalled fetch read seen before the redirect", $time);
			other_errors++;
			ok = 1'b0;
			return;
		end
		@(posedge clk);
		#1;
		redirect_valid = 1'b1;
		redirect_pc = target;
		@(posedge clk);
		#1;
		redirect_valid = 1'b0;
	endtask

	task automatic run_data_op(input mem_op_e op, input word_t addr, input word_t wdata,
			input word_t expected, output logic ok);
		int n;
		ok = 1'b0;
		data_req_valid = 1'b1;
		data_req = {op, addr, wdata};
		n = 0;
		@(negedge clk);
		while (!data_req_ready && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (!data_req_ready) begin
			$display("** Error at %0t: data request was never accepted", $time);
			other_errors++;
			return;
		end
		@(posedge clk);
		#1;
		data_req_valid = 1'b0;
		req_count++;
		n = 0;
		@(negedge clk);
		while (!(data_resp_valid && data_resp_ready) && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (!(data_resp_valid && data_resp_ready)) begin
			$display("** Error at %0t: no data response for op %h at %h", $time, op, addr);
			other_errors++;
			return;
		end
		if (op inside {op_sb, op_sh, op_sw}) begin
			assert (load_data == 32'd0) else begin
				$display("** Error at %0t: load_data = %h, expected %h", $time, load_data, 32'd0);
				value_errors++;
			end
			assert (mem_read(addr) == expected) else begin
				$display("** Error at %0t: mem[%h] = %h, expected %h",
					$time, addr, mem_read(addr), expected);
				value_errors++;
			end
		end else begin
			assert (load_data == expected) else begin
				$display("** Error at %0t: load_data = %h, expected %h", $time, load_data, expected);
				value_errors++;
			end
		end
		@(posedge clk);
		#1;
		ok = 1'b1;
	endtask

	initial begin
		int fd;
		int cnt;
		string line;
		word_t f0, f1, f2, f3;
		logic ok;
		fd = $fopen("verif/mem_trace.txt", "r");
		ok = fd != 0;
		if (!ok) begin
			$display("** Error: cannot open verif/mem_trace.txt");
			other_errors++;
		end
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		while (ok && !$feof(fd)) begin
			line = "";
			cnt = $fgets(line, fd);
			if (cnt > 0 && line.len() > 2) begin
				cnt = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", f0, f1, f2, f3);
				case (line.getc(0))
					"P": mem[f0[31:2]] = f1;
					"R": run_redirect(f0, f1, ok);
					"D": run_data_op(mem_op_e'(f0[5:0]), f1, f2, f3, ok);
					default: ;
				endcase
			end
		end
		// fetch must keep flowing after the last redirect
		if (ok)
			wait_for_instrs(4, ok);
		if (fd != 0)
			$fclose(fd);
		repeat (2) @(posedge clk);
		$display("value errors: %0d, stream errors: %0d, other errors: %0d, bus assertion errors: %0d",
			value_errors, monitor_errors, other_errors, dut.u_arbiter.bus_checks.failures);
		if (value_errors == 0 && monitor_errors == 0 && other_errors == 0
				&& dut.u_arbiter.bus_checks.failures == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/mem_trace.txt ====
# P addr word | R target_pc instrs_before | D opcode addr wdata expected
# opcodes 20 lb 21 lh 23 lw 24 lbu 25 lhu 28 sb 29 sh 2b sw; a store expects the memory word after it
P bfc00000 3c081000
P bfc00004 8d090000
P bfc00008 a1090003
P bfc0000c 1000fffd
P bfc00100 24020001
P bfc00104 ac020004
P 00001000 8a7b6c5d
P 00001004 00000000
R bfc00100 5
D 20 00001000 00000000 0000005d
D 20 00001001 00000000 0000006c
D 20 00001002 00000000 0000007b
D 20 00001003 00000000 ffffff8a
D 24 00001003 00000000 0000008a
D 21 00001002 00000000 ffff8a7b
D 25 00001000 00000000 00006c5d
D 25 00001002 00000000 00008a7b
D 23 00001000 00000000 8a7b6c5d
R bfc00008 3
D 28 00001004 000000a1 000000a1
D 28 00001005 000000b2 0000b2a1
D 28 00001006 000000c3 00c3b2a1
D 28 00001007 000000d4 d4c3b2a1
D 29 00001006 1234f00d f00db2a1
D 29 00001004 00009876 f00d9876
D 2b 00001008 cafe1234 cafe1234
R bfc00000 2
D 23 00001004 00000000 f00d9876
D 21 00001006 00000000 fffff00d
D 24 00001005 00000000 00000098
D 20 00001004 00000000 00000076
D 23 00001008 00000000 cafe1234

// ==== filelist.f ====
common/mem_pkg.sv
fetch/instr_fetch.sv
data/load_store_lane.sv
logic/bus_arbiter.sv
logic/mips_mem_bus.sv
verif/mips_mem_bus_sva.sv
verif/tb_mips_mem_bus.sv

// ==== Makefile ====
TOP = tb_mips_mem_bus

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null

clean:
	rm -rf obj_dir

.PHONY: sim clean
